//--- ddr3_front.f
ddr3_ui_pkg.sv
ddr3_acq_pkg.sv
ddr3_cmd_arbiter.sv
ddr3_wr_control.sv
ddr3_rd_control.sv
ddr3_front.sv
ddr3_front_chk.sv
tb_ddr3_front.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_ddr3_front -f ddr3_front.f -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_ddr3_front.sv
`timescale 1ns/1ps

module tb_ddr3_front
    import ddr3_ui_pkg::*, ddr3_acq_pkg::*;
();

    localparam int MEM_BURSTS_TB = 64;
    localparam int TIMEOUT = 2000;
    localparam int RD_LATENCY = 4;

    logic        ddr3_domain_clk;
    logic        rst_n;
    logic        acq_enabled;
    logic        acq_done;
    burst_addr_t fixed_start_addr;
    logic        en_fixed_start_addr;
    burst_addr_t rd_start_addr;
    burst_cnt_t  rd_burst_cnt;
    logic        enable_reading;
    logic        rd_fifo_almost_full;
    // driven by the FIFO and memory models
    app_data_t   wr_fifo_dat = '0;
    logic        wr_fifo_empty = 1'b1;
    logic        app_rdy = 1'b0;
    logic        app_wdf_rdy = 1'b0;
    app_data_t   app_rd_data = '0;
    logic        app_rd_data_valid = 1'b0;
    // DUT outputs
    logic        wr_fifo_rd_en;
    logic        wr_done;
    logic        reading_done;
    logic        rd_fifo_wr_en;
    app_data_t   rd_fifo_dat;
    logic        rd_fifo_tlast;
    app_addr_t   app_addr;
    app_cmd_t    app_cmd;
    logic        app_en;
    app_data_t   app_wdf_data;
    logic        app_wdf_wren;
    logic        app_wdf_end;

    // model state
    app_data_t   fifo_q[$];
    app_data_t   mem[app_addr_t];
    app_addr_t   wr_cmd_q[$];
    app_data_t   wr_dat_q[$];
    app_addr_t   wr_log_addr[$];
    app_data_t   wr_log_data[$];
    app_addr_t   rd_pend_addr[$];
    int          rd_pend_due[$];
    app_data_t   cap_data[$];
    logic        cap_last[$];
    int          pop_count = 0;
    int          cycle = 0;
    int          model_errors = 0;
    bit [31:0]   lfsr_state = 32'h8829_9e86;
    int          errors;
    int          checks;
    int          tests;

    ddr3_front #(
        .MEM_BURSTS(burst_cnt_t'(MEM_BURSTS_TB))
    ) DUT (.*);

    initial begin
        ddr3_domain_clk = 1'b0;
        forever #10 ddr3_domain_clk = ~ddr3_domain_clk;
    end

    //**************************************************************************
    // helpers
    //**************************************************************************

    // fibonacci LFSR with taps 32 22 2 1
    // stepped once per bit
    function bit rand_bit();
        bit fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // memory content that depends on every address bit
    function automatic app_data_t fill_word(app_addr_t a);
        return {5'd0, a, 5'd3, ~a, 5'd5, a ^ 27'h5a5_a5a5, 5'd7, a + 27'd1};
    endfunction

    function automatic app_data_t make_word(int tag, int i);
        return {32'(tag), 32'(i), ~32'(tag), 32'hfeed_0000 ^ 32'(i)};
    endfunction

    function automatic app_addr_t burst_to_app(int start, int i);
        return app_addr_t'((start + i) % MEM_BURSTS_TB) << BURST_ADDR_SHIFT;
    endfunction

    task automatic step();
        @(posedge ddr3_domain_clk);
        #2;
    endtask

    task automatic note_failure(string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic compare_addr(string name, app_addr_t exp, app_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_data(string name, app_data_t exp, app_data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_flag(string name, bit exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_count(string name, burst_cnt_t exp, burst_cnt_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic finish_test(string name, int err0);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    //**************************************************************************
    // FIFO and memory model
    //**************************************************************************
    always @(posedge ddr3_domain_clk) begin
        cycle++;
        if (!rst_n) begin
            // preload the whole region while in reset
            for (int b = 0; b < MEM_BURSTS_TB; b++)
                mem[burst_to_app(b, 0)] = fill_word(burst_to_app(b, 0));
        end else begin
            if (app_en && app_rdy) begin
                if (app_cmd == APP_CMD_WRITE) begin
                    wr_cmd_q.push_back(app_addr);
                end else if (app_cmd == APP_CMD_READ) begin
                    rd_pend_addr.push_back(app_addr);
                    rd_pend_due.push_back(cycle + RD_LATENCY);
                end else begin
                    model_errors++;
                    $display("error: unknown command code on the memory port");
                end
            end
            if (app_wdf_wren && app_wdf_rdy)
                wr_dat_q.push_back(app_wdf_data);
            // pair command and data in order
            while (wr_cmd_q.size() != 0 && wr_dat_q.size() != 0) begin
                mem[wr_cmd_q[0]] = wr_dat_q[0];
                wr_log_addr.push_back(wr_cmd_q.pop_front());
                wr_log_data.push_back(wr_dat_q.pop_front());
            end
            if (wr_fifo_rd_en) begin
                pop_count++;
                if (fifo_q.size() != 0) begin
                    void'(fifo_q.pop_front());
                end else begin
                    model_errors++;
                    $display("error: write FIFO popped while empty");
                end
            end
            if (rd_fifo_wr_en) begin
                cap_data.push_back(rd_fifo_dat);
                cap_last.push_back(rd_fifo_tlast);
            end
        end
        #2;
        // ready about three cycles in four
        app_rdy = rand_bit() | rand_bit();
        app_wdf_rdy = rand_bit() | rand_bit();
        wr_fifo_empty = (fifo_q.size() == 0);
        wr_fifo_dat = (fifo_q.size() != 0) ? fifo_q[0] : '0;
        // in-order read return of one burst per cycle
        if (rd_pend_addr.size() != 0 && rd_pend_due[0] <= cycle) begin
            app_rd_data_valid = 1'b1;
            app_rd_data = mem.exists(rd_pend_addr[0]) ? mem[rd_pend_addr[0]]
                                                      : fill_word(rd_pend_addr[0]);
            void'(rd_pend_addr.pop_front());
            void'(rd_pend_due.pop_front());
        end else begin
            app_rd_data_valid = 1'b0;
        end
    end

    //**************************************************************************
    // directed tests
    //**************************************************************************
    task automatic write_batch(string name, int start, int n, bit fixed, int tag);
        int err0;
        int pop0;
        int log0;
        int first;
        int k;
        err0 = errors;
        pop0 = pop_count;
        log0 = wr_log_addr.size();
        // fixed start address only counts while its enable is high
        first = fixed ? start : 0;
        en_fixed_start_addr = fixed;
        fixed_start_addr = burst_addr_t'(start);
        for (int i = 0; i < n; i++)
            fifo_q.push_back(make_word(tag, i));
        step();
        acq_enabled = 1'b1;
        k = 0;
        while (pop_count - pop0 < n && k < TIMEOUT) begin
            step();
            k++;
        end
        if (pop_count - pop0 < n)
            note_failure({name, ": timeout waiting for the FIFO pops"});
        repeat (5) step();
        compare_count({name, " pops"}, burst_cnt_t'(n), burst_cnt_t'(pop_count - pop0));
        compare_count({name, " writes"}, burst_cnt_t'(n),
                      burst_cnt_t'(wr_log_addr.size() - log0));
        for (int i = 0; i < n && log0 + i < wr_log_addr.size(); i++) begin
            compare_addr({name, " addr"}, burst_to_app(first, i), wr_log_addr[log0 + i]);
            compare_data({name, " data"}, make_word(tag, i), wr_log_data[log0 + i]);
        end
        acq_enabled = 1'b0;
        step();
        finish_test(name, err0);
    endtask

    task automatic read_span(string name, int start, int cnt, int bp_from, int bp_len);
        int err0;
        int base;
        int k;
        int got;
        err0 = errors;
        base = cap_data.size();
        rd_start_addr = burst_addr_t'(start);
        rd_burst_cnt = burst_cnt_t'(cnt);
        enable_reading = 1'b1;
        step();
        enable_reading = 1'b0;
        k = 0;
        while (!reading_done && k < TIMEOUT) begin
            // almost full for a stretch in the middle
            rd_fifo_almost_full = (k >= bp_from && k < bp_from + bp_len);
            step();
            k++;
        end
        rd_fifo_almost_full = 1'b0;
        if (!reading_done)
            note_failure({name, ": timeout waiting for reading_done"});
        repeat (6) step();
        got = cap_data.size() - base;
        compare_count({name, " bursts"}, burst_cnt_t'(cnt), burst_cnt_t'(got));
        for (int i = 0; i < got && i < cnt; i++) begin
            compare_data({name, " data"}, fill_word(burst_to_app(start, i)), cap_data[base + i]);
            compare_flag({name, " tlast"}, (i == cnt - 1), cap_last[base + i]);
        end
        compare_flag({name, " reading_done"}, 1'b1, reading_done);
        finish_test(name, err0);
    endtask

    task automatic write_done_flag(string name);
        int err0;
        int pop0;
        int k;
        err0 = errors;
        pop0 = pop_count;
        en_fixed_start_addr = 1'b0;
        for (int i = 0; i < 4; i++)
            fifo_q.push_back(make_word(55, i));
        step();
        acq_enabled = 1'b1;
        acq_done = 1'b1;
        k = 0;
        while (pop_count - pop0 < 4 && k < TIMEOUT) begin
            if (fifo_q.size() != 0)
                compare_flag({name, " early"}, 1'b0, wr_done);
            step();
            k++;
        end
        k = 0;
        while (!wr_done && k < TIMEOUT) begin
            step();
            k++;
        end
        if (!wr_done)
            note_failure({name, ": wr_done never rose after the FIFO drained"});
        acq_enabled = 1'b0;
        acq_done = 1'b0;
        step();
        step();
        compare_flag({name, " cleared"}, 1'b0, wr_done);
        finish_test(name, err0);
    endtask

    //**************************************************************************
    // main sequence
    //**************************************************************************
    initial begin
        rst_n = 1'b0;
        acq_enabled = 1'b0;
        acq_done = 1'b0;
        fixed_start_addr = '0;
        en_fixed_start_addr = 1'b0;
        rd_start_addr = '0;
        rd_burst_cnt = '0;
        enable_reading = 1'b0;
        rd_fifo_almost_full = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        repeat (4) @(posedge ddr3_domain_clk);
        #2;
        rst_n = 1'b1;
        step();
        // reads run first while the region still holds the preload
        read_span("read_span", 5, 12, 0, 0);
        read_span("read_backpressure", 50, 20, 4, 15);
        // fixed start address set but not enabled
        write_batch("writes_from_zero", 45, 10, 1'b0, 11);
        write_batch("fixed_start_wrap", 60, 8, 1'b1, 22);
        write_done_flag("write_done");
        fork
            write_batch("concurrent_write", 20, 10, 1'b1, 33);
            read_span("concurrent_read", 40, 16, 6, 8);
        join
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors + model_errors);
        if (errors + model_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- ddr3_front_chk.sv
`timescale 1ns/1ps

module ddr3_front_chk
    import ddr3_ui_pkg::*;
(
    input logic      ddr3_domain_clk,
    input logic      rst_n,
    input logic      app_en,
    input logic      app_rdy,
    input app_addr_t app_addr,
    input app_cmd_t  app_cmd,
    input logic      app_wdf_wren,
    input logic      app_wdf_rdy,
    input logic      app_wdf_end,
    input logic      rd_req_en,
    input logic      rd_req_rdy,
    input logic      rd_fifo_almost_full
);

    // command held stable until taken
    assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_en && !app_rdy |=> app_en && $stable(app_addr) && $stable(app_cmd))
        else $error("command dropped or changed before app_rdy");

    // write data strobe held until taken
    assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren)
        else $error("app_wdf_wren dropped before app_wdf_rdy");

    // only a held read command may stay up under back-pressure
    assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        rd_fifo_almost_full && !($past(rd_req_en) && !$past(rd_req_rdy)) |-> !rd_req_en)
        else $error("new read command raised while read FIFO almost full");

    // single-beat bursts
    assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_wdf_end == app_wdf_wren)
        else $error("app_wdf_end differs from app_wdf_wren");

endmodule

bind ddr3_front ddr3_front_chk u_front_chk (
    .ddr3_domain_clk(ddr3_domain_clk), .rst_n(rst_n),
    .app_en(app_en), .app_rdy(app_rdy), .app_addr(app_addr), .app_cmd(app_cmd),
    .app_wdf_wren(app_wdf_wren), .app_wdf_rdy(app_wdf_rdy), .app_wdf_end(app_wdf_end),
    .rd_req_en(rd_req_en), .rd_req_rdy(rd_req_rdy),
    .rd_fifo_almost_full(rd_fifo_almost_full)
);

//--- ddr3_front.sv
`timescale 1ns/1ps

module ddr3_front
    import ddr3_ui_pkg::*, ddr3_acq_pkg::*;
#(
    parameter burst_cnt_t MEM_BURSTS = MEM_BURSTS_DEFAULT
) (
    input  logic        ddr3_domain_clk,
    input  logic        rst_n,
    // acquisition FIFO
    input  app_data_t   wr_fifo_dat,
    input  logic        wr_fifo_empty,
    output logic        wr_fifo_rd_en,
    // acquisition control
    input  logic        acq_enabled,
    input  logic        acq_done,
    input  burst_addr_t fixed_start_addr,
    input  logic        en_fixed_start_addr,
    output logic        wr_done,
    // read request
    input  burst_addr_t rd_start_addr,
    input  burst_cnt_t  rd_burst_cnt,
    input  logic        enable_reading,
    output logic        reading_done,
    // read FIFO
    output logic        rd_fifo_wr_en,
    output app_data_t   rd_fifo_dat,
    output logic        rd_fifo_tlast,
    input  logic        rd_fifo_almost_full,
    // memory command port
    output app_addr_t   app_addr,
    output app_cmd_t    app_cmd,
    output logic        app_en,
    input  logic        app_rdy,
    // memory write data port
    output app_data_t   app_wdf_data,
    output logic        app_wdf_wren,
    output logic        app_wdf_end,
    input  logic        app_wdf_rdy,
    // memory read return port
    input  app_data_t   app_rd_data,
    input  logic        app_rd_data_valid
);

    // request channels into the arbiter
    burst_addr_t wr_req_addr;
    logic        wr_req_en;
    logic        wr_req_rdy;
    burst_addr_t rd_req_addr;
    logic        rd_req_en;
    logic        rd_req_rdy;

    // FIFO head goes straight to the memory
    assign app_wdf_data = wr_fifo_dat;

    //**************************************************************************
    // write path, read path and shared command port
    //**************************************************************************
    ddr3_wr_control #(
        .MEM_BURSTS(MEM_BURSTS)
    ) u_wr_control (
        .ddr3_domain_clk(ddr3_domain_clk), .rst_n(rst_n),
        .acq_enabled(acq_enabled), .acq_done(acq_done),
        .fixed_start_addr(fixed_start_addr), .en_fixed_start_addr(en_fixed_start_addr),
        .wr_done(wr_done), .wr_fifo_empty(wr_fifo_empty), .wr_fifo_rd_en(wr_fifo_rd_en),
        .wr_req_addr(wr_req_addr), .wr_req_en(wr_req_en), .wr_req_rdy(wr_req_rdy),
        .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end), .app_wdf_rdy(app_wdf_rdy)
    );

    ddr3_rd_control #(
        .MEM_BURSTS(MEM_BURSTS)
    ) u_rd_control (
        .ddr3_domain_clk(ddr3_domain_clk), .rst_n(rst_n),
        .rd_start_addr(rd_start_addr), .rd_burst_cnt(rd_burst_cnt),
        .enable_reading(enable_reading), .reading_done(reading_done),
        .rd_req_addr(rd_req_addr), .rd_req_en(rd_req_en), .rd_req_rdy(rd_req_rdy),
        .app_rd_data(app_rd_data), .app_rd_data_valid(app_rd_data_valid),
        .rd_fifo_wr_en(rd_fifo_wr_en), .rd_fifo_dat(rd_fifo_dat),
        .rd_fifo_tlast(rd_fifo_tlast), .rd_fifo_almost_full(rd_fifo_almost_full)
    );

    ddr3_cmd_arbiter u_cmd_arbiter (
        .ddr3_domain_clk(ddr3_domain_clk), .rst_n(rst_n),
        .wr_req_addr(wr_req_addr), .wr_req_en(wr_req_en), .wr_req_rdy(wr_req_rdy),
        .rd_req_addr(rd_req_addr), .rd_req_en(rd_req_en), .rd_req_rdy(rd_req_rdy),
        .app_addr(app_addr), .app_cmd(app_cmd), .app_en(app_en), .app_rdy(app_rdy)
    );

endmodule

//--- ddr3_rd_control.sv
`timescale 1ns/1ps

module ddr3_rd_control
    import ddr3_ui_pkg::*, ddr3_acq_pkg::*;
#(
    parameter burst_cnt_t MEM_BURSTS = MEM_BURSTS_DEFAULT
) (
    input  logic        ddr3_domain_clk,
    input  logic        rst_n,
    // read request
    input  burst_addr_t rd_start_addr,
    input  burst_cnt_t  rd_burst_cnt,
    input  logic        enable_reading,
    output logic        reading_done,
    // request channel to the arbiter
    output burst_addr_t rd_req_addr,
    output logic        rd_req_en,
    input  logic        rd_req_rdy,
    // memory read return
    input  app_data_t   app_rd_data,
    input  logic        app_rd_data_valid,
    // read FIFO
    output logic        rd_fifo_wr_en,
    output app_data_t   rd_fifo_dat,
    output logic        rd_fifo_tlast,
    input  logic        rd_fifo_almost_full
);

    // commands still to issue
    burst_cnt_t cmd_left;
    // bursts still to come back
    burst_cnt_t ret_left;
    // enable was up last cycle without acceptance
    logic       held;
    logic       cmd_accept;
    logic       ret_valid;
    logic       ret_last;

    //**************************************************************************
    // command issue
    //**************************************************************************

    // new commands wait out back-pressure, a held one stays up
    assign rd_req_en  = (cmd_left != '0) & (held | ~rd_fifo_almost_full);
    assign cmd_accept = rd_req_en & rd_req_rdy;

    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            cmd_left    <= '0;
            held        <= 1'b0;
            rd_req_addr <= '0;
        end else if (enable_reading) begin
            cmd_left    <= rd_burst_cnt;
            held        <= 1'b0;
            rd_req_addr <= rd_start_addr;
        end else begin
            held <= rd_req_en & ~rd_req_rdy;
            if (cmd_accept) begin
                cmd_left    <= cmd_left - burst_cnt_t'(1);
                // wrap at the end of the region
                rd_req_addr <= next_burst_addr(rd_req_addr, MEM_BURSTS);
            end
        end
    end

    //**************************************************************************
    // data return
    //**************************************************************************

    // only bursts that belong to the current span
    assign ret_valid = app_rd_data_valid & (ret_left != '0);
    assign ret_last  = ret_valid & (ret_left == burst_cnt_t'(1));

    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            ret_left      <= '0;
            rd_fifo_wr_en <= 1'b0;
            rd_fifo_tlast <= 1'b0;
            reading_done  <= 1'b0;
        end else begin
            // one cycle behind the memory valid
            rd_fifo_wr_en <= ret_valid;
            rd_fifo_tlast <= ret_last;
            if (enable_reading) begin
                ret_left     <= rd_burst_cnt;
                // empty span is done at once
                reading_done <= (rd_burst_cnt == '0);
            end else begin
                if (ret_valid)
                    ret_left <= ret_left - burst_cnt_t'(1);
                // after the final FIFO write
                if (rd_fifo_wr_en && rd_fifo_tlast)
                    reading_done <= 1'b1;
            end
        end
    end

    // burst payload register
    always_ff @(posedge ddr3_domain_clk) begin
        if (app_rd_data_valid)
            rd_fifo_dat <= app_rd_data;
    end

endmodule

//--- ddr3_wr_control.sv
`timescale 1ns/1ps

module ddr3_wr_control
    import ddr3_acq_pkg::*;
#(
    parameter burst_cnt_t MEM_BURSTS = MEM_BURSTS_DEFAULT
) (
    input  logic        ddr3_domain_clk,
    input  logic        rst_n,
    // acquisition control
    input  logic        acq_enabled,
    input  logic        acq_done,
    input  burst_addr_t fixed_start_addr,
    input  logic        en_fixed_start_addr,
    output logic        wr_done,
    // acquisition FIFO
    input  logic        wr_fifo_empty,
    output logic        wr_fifo_rd_en,
    // request channel to the arbiter
    output burst_addr_t wr_req_addr,
    output logic        wr_req_en,
    input  logic        wr_req_rdy,
    // memory write data strobes
    output logic        app_wdf_wren,
    output logic        app_wdf_end,
    input  logic        app_wdf_rdy
);

    logic acq_enabled_q;
    logic acq_rise;
    logic acq_fall;
    // a head word is in progress
    logic busy;
    // command / data taken by the end of this cycle
    logic cmd_done;
    logic data_done;
    logic word_done;
    logic start_word;
    logic acq_done_seen;

    assign acq_rise = acq_enabled & ~acq_enabled_q;
    assign acq_fall = ~acq_enabled & acq_enabled_q;

    assign busy      = wr_req_en | app_wdf_wren;
    assign cmd_done  = ~wr_req_en | wr_req_rdy;
    assign data_done = ~app_wdf_wren | app_wdf_rdy;
    assign word_done = busy & cmd_done & data_done;

    // no start during the pop cycle, FIFO head is about to change
    assign start_word = acq_enabled & acq_enabled_q & ~wr_fifo_empty & ~busy & ~wr_fifo_rd_en;

    // single-beat bursts
    assign app_wdf_end = app_wdf_wren;

    //**************************************************************************
    // command and data strobes, FIFO pop
    //**************************************************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            acq_enabled_q <= 1'b0;
            wr_req_en     <= 1'b0;
            app_wdf_wren  <= 1'b0;
            wr_fifo_rd_en <= 1'b0;
        end else begin
            acq_enabled_q <= acq_enabled;
            // pop one cycle after the later of the two acceptances
            wr_fifo_rd_en <= word_done;
            if (start_word) begin
                wr_req_en    <= 1'b1;
                app_wdf_wren <= 1'b1;
            end else begin
                // each side drops on its own acceptance
                if (wr_req_en && wr_req_rdy)
                    wr_req_en <= 1'b0;
                if (app_wdf_wren && app_wdf_rdy)
                    app_wdf_wren <= 1'b0;
            end
        end
    end

    // burst address, reloaded on acquisition start
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n)
            wr_req_addr <= '0;
        else if (acq_rise)
            wr_req_addr <= en_fixed_start_addr ? fixed_start_addr : '0;
        else if (word_done)
            wr_req_addr <= next_burst_addr(wr_req_addr, MEM_BURSTS);
    end

    //**************************************************************************
    // done flag
    //**************************************************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            acq_done_seen <= 1'b0;
            wr_done       <= 1'b0;
        end else if (acq_fall) begin
            acq_done_seen <= 1'b0;
            wr_done       <= 1'b0;
        end else begin
            if (acq_enabled && acq_done)
                acq_done_seen <= 1'b1;
            // drained, nothing pending and no pop in flight
            if (acq_done_seen && wr_fifo_empty && !busy && !wr_fifo_rd_en)
                wr_done <= 1'b1;
        end
    end

endmodule

//--- ddr3_cmd_arbiter.sv
`timescale 1ns/1ps

module ddr3_cmd_arbiter
    import ddr3_ui_pkg::*, ddr3_acq_pkg::*;
(
    input  logic        ddr3_domain_clk,
    input  logic        rst_n,
    // write controller channel
    input  burst_addr_t wr_req_addr,
    input  logic        wr_req_en,
    output logic        wr_req_rdy,
    // read controller channel
    input  burst_addr_t rd_req_addr,
    input  logic        rd_req_en,
    output logic        rd_req_rdy,
    // memory command port
    output app_addr_t   app_addr,
    output app_cmd_t    app_cmd,
    output logic        app_en,
    input  logic        app_rdy
);

    // side holding the grant, 1 = read
    logic        grant_rd;
    // granted command was enabled but not yet taken
    logic        locked;
    // combinational choice for this cycle
    logic        sel_rd;
    burst_addr_t sel_addr;

    //**************************************************************************
    // grant selection
    //**************************************************************************
    always_comb begin
        if (locked)
            // hold the side that still waits for app_rdy
            sel_rd = grant_rd;
        else if (wr_req_en && rd_req_en)
            // both want the port, take turns
            sel_rd = ~grant_rd;
        else if (rd_req_en)
            sel_rd = 1'b1;
        else if (wr_req_en)
            sel_rd = 1'b0;
        else
            sel_rd = grant_rd;
    end

    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            grant_rd <= 1'b0;
            locked   <= 1'b0;
        end else begin
            grant_rd <= sel_rd;
            locked   <= app_en & ~app_rdy;
        end
    end

    //**************************************************************************
    // command port mux
    //**************************************************************************
    assign sel_addr = sel_rd ? rd_req_addr : wr_req_addr;

    // burst address to column granularity, rank bit stays zero
    assign app_addr = app_addr_t'(sel_addr) << BURST_ADDR_SHIFT;
    assign app_cmd  = sel_rd ? APP_CMD_READ : APP_CMD_WRITE;
    assign app_en   = sel_rd ? rd_req_en : wr_req_en;

    // only the granted side sees the memory ready
    assign wr_req_rdy = ~sel_rd & app_rdy;
    assign rd_req_rdy = sel_rd & app_rdy;

endmodule

//--- ddr3_acq_pkg.sv
package ddr3_acq_pkg;

    //**************************************************************************
    // acquisition side addressing
    //**************************************************************************

    // burst address, one step per 128-bit burst
    typedef logic [22:0] burst_addr_t;

    // number of bursts, one bit wider than the address
    typedef logic [23:0] burst_cnt_t;

    // full memory region, 2^23 bursts
    localparam burst_cnt_t MEM_BURSTS_DEFAULT = 24'h80_0000;

    // next burst address, wraps to zero after the last burst of the region
    function automatic burst_addr_t next_burst_addr(burst_addr_t addr, burst_cnt_t region);
        burst_cnt_t last;
        last = region - burst_cnt_t'(1);
        if (burst_cnt_t'(addr) >= last)
            return '0;
        return addr + burst_addr_t'(1);
    endfunction

endpackage

//--- ddr3_ui_pkg.sv
package ddr3_ui_pkg;

    //**************************************************************************
    // memory application interface
    //**************************************************************************

    // app address is rank, bank, row and column
    typedef logic [26:0] app_addr_t;

    // command codes as the memory core defines them
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'b000,
        APP_CMD_READ  = 3'b001
    } app_cmd_t;

    // one burst of eight beats of a 16-bit device
    typedef logic [127:0] app_data_t;

    // column bits covered by one burst
    // app address = burst address << BURST_ADDR_SHIFT
    // rank bit stays zero
    localparam int BURST_ADDR_SHIFT = 3;

endpackage
